//--- filelist.f
+incdir+hw
hw/noc_pkg.sv
hw/noc_input_stage.sv
hw/noc_route_calc.sv
hw/noc_switch_alloc.sv
hw/noc_router.sv
verification/noc_router_checker.sv
verification/noc_router_tb.sv

//--- hw/noc_cfg.svh
/*
  Mesh NoC router configuration
  Mesh size, flit payload width and router port count
*/

`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// Mesh topology
// --------------------------------------------------
`define NOC_X_NODES 4   // Node columns
`define NOC_Y_NODES 4   // Node rows

// Flit payload
// --------------------------------------------------
`define NOC_DATA_W  16  // Data bits carried per flit

// Router ports
// --------------------------------------------------
`define NOC_PORTS   5   // Core, north, east, south, west
`define NOC_PORT_W  3   // Bits to index one port

// Coordinate widths follow the mesh size
`define NOC_X_W     $clog2(`NOC_X_NODES)
`define NOC_Y_W     $clog2(`NOC_Y_NODES)

`endif

//--- hw/noc_input_stage.sv
/*
  Router input stage
  One flit hold register per port, loaded on a strobe into an
  empty slot and freed when the switch allocator grants it
*/

`timescale 1ns/1ps

`include "noc_cfg.svh"

module noc_input_stage
  import noc_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  flit_t                 i_in_flit [`NOC_PORTS],  // Flits from neighbours and core
  input  logic [`NOC_PORTS-1:0] i_in_val,                // One strobe per flit
  input  logic [`NOC_PORTS-1:0] i_grant,                 // Slot won its output this cycle
  output flit_t                 o_held_flit [`NOC_PORTS],
  output logic [`NOC_PORTS-1:0] o_held_val               // Also the busy level seen outside
);

  logic [`NOC_PORTS-1:0] load;  // Strobe lands in an empty slot

  // A strobe against a full slot is a sender error and is ignored
  assign load = i_in_val & ~o_held_val;

  // Hold registers
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    for (int p = 0; p < `NOC_PORTS; p++) begin
      if (load[p]) begin
        o_held_flit[p] <= i_in_flit[p];  // Capture at the strobe edge
      end
    end
  end

  // Slot occupancy
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_held_val <= '0;
    end else begin
      for (int p = 0; p < `NOC_PORTS; p++) begin
        if (i_grant[p]) begin
          o_held_val[p] <= 1'b0;  // Flit moves to the output register now
        end else if (load[p]) begin
          o_held_val[p] <= 1'b1;
        end
      end
    end
  end

  // Grant and load cannot meet on one slot
  // grant needs a full slot, load needs an empty one

endmodule

//--- hw/noc_pkg.sv
/*
  Mesh NoC router types
  Flit layout, port numbering and one-hot output requests
*/

`include "noc_cfg.svh"

package noc_pkg;

  // Port numbering
  // --------------------------------------------------
  typedef enum logic [`NOC_PORT_W-1:0] {
    PORT_C = 3'd0,  // Local core
    PORT_N = 3'd1,  // Towards increasing y
    PORT_E = 3'd2,  // Towards increasing x
    PORT_S = 3'd3,  // Towards decreasing y
    PORT_W = 3'd4   // Towards decreasing x
  } port_e;

  // Flit layout
  // --------------------------------------------------
  typedef struct packed {
    logic [`NOC_X_W-1:0]    x_dest;  // Destination column
    logic [`NOC_Y_W-1:0]    y_dest;  // Destination row
    logic [`NOC_DATA_W-1:0] data;    // Payload
  } flit_t;

  // One-hot output request, bit 0 is the core port
  // Index with port_e, so req[PORT_E] asks for east
  typedef logic [0:`NOC_PORTS-1] port_req_t;

endpackage

//--- hw/noc_route_calc.sv
/*
  XY route calculator
  Compares a held flit's destination with this node's place and
  raises a one-hot request for the output it must leave on
*/

`timescale 1ns/1ps

module noc_route_calc
  import noc_pkg::*;
#(
  parameter integer X_LOC = 0,  // Node column
  parameter integer Y_LOC = 0   // Node row
)
(
  input  flit_t     i_flit,        // Held flit
  input  logic      i_val,         // Flit present
  output port_req_t o_output_req   // One-hot [c,n,e,s,w] request
);

  // Own place at the flit's coordinate width
  localparam logic [$bits(i_flit.x_dest)-1:0] X_HERE = X_LOC[$bits(i_flit.x_dest)-1:0];
  localparam logic [$bits(i_flit.y_dest)-1:0] Y_HERE = Y_LOC[$bits(i_flit.y_dest)-1:0];

  // Dimension ordered routing, x resolved before y
  // --------------------------------------------------
  always_comb begin
    o_output_req = '0;                          // No flit, no request
    if (i_val) begin
      if (i_flit.x_dest != X_HERE) begin
        if (i_flit.x_dest > X_HERE) begin
          o_output_req[PORT_E] = 1'b1;          // Head east
        end else begin
          o_output_req[PORT_W] = 1'b1;          // Head west
        end
      end else if (i_flit.y_dest != Y_HERE) begin
        if (i_flit.y_dest > Y_HERE) begin
          o_output_req[PORT_N] = 1'b1;          // Head north
        end else begin
          o_output_req[PORT_S] = 1'b1;          // Head south
        end
      end else begin
        o_output_req[PORT_C] = 1'b1;            // Arrived, hand to core
      end
    end
  end

endmodule

//--- hw/noc_router.sv
/*
  Mesh NoC router node
  Five port XY router: input hold registers, route calculators
  per input and a round-robin switch with registered outputs
*/

`timescale 1ns/1ps

`include "noc_cfg.svh"

module noc_router
  import noc_pkg::*;
#(
  parameter integer X_LOC = 0,  // Node column in the mesh
  parameter integer Y_LOC = 0   // Node row in the mesh
)
(
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  flit_t                 i_in_flit [`NOC_PORTS],  // Indexed by port_e
  input  logic [`NOC_PORTS-1:0] i_in_val,
  output logic [`NOC_PORTS-1:0] o_in_busy,               // Do not strobe while high
  output flit_t                 o_out_flit [`NOC_PORTS],
  output logic [`NOC_PORTS-1:0] o_out_val
);

  flit_t                 held_flit [`NOC_PORTS];  // Flits waiting for the switch
  logic [`NOC_PORTS-1:0] held_val;
  port_req_t             req [`NOC_PORTS];        // Output request per input
  logic [`NOC_PORTS-1:0] grant;                   // Input won this cycle

  assign o_in_busy = held_val;  // A full slot is the only back-pressure

  // Input hold registers
  // --------------------------------------------------
  noc_input_stage i_input_stage (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_in_flit   (i_in_flit),
    .i_in_val    (i_in_val),
    .i_grant     (grant),
    .o_held_flit (held_flit),
    .o_held_val  (held_val)
  );

  // One route calculator per input
  // --------------------------------------------------
  for (genvar p = 0; p < `NOC_PORTS; p++) begin : g_route
    noc_route_calc #(
      .X_LOC (X_LOC),
      .Y_LOC (Y_LOC)
    ) i_route_calc (
      .i_flit       (held_flit[p]),
      .i_val        (held_val[p]),
      .o_output_req (req[p])
    );
  end

  // Arbitration and crossbar
  // --------------------------------------------------
  noc_switch_alloc i_switch_alloc (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_req       (req),
    .i_held_flit (held_flit),
    .o_grant     (grant),
    .o_out_flit  (o_out_flit),
    .o_out_val   (o_out_val)
  );

endmodule

//--- hw/noc_switch_alloc.sv
/*
  Switch allocator and crossbar
  Round-robin pick of one requesting input per output, then the
  chosen flit is registered onto that output with a valid strobe
*/

`timescale 1ns/1ps

`include "noc_cfg.svh"

module noc_switch_alloc
  import noc_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  port_req_t             i_req [`NOC_PORTS],        // Request row per input
  input  flit_t                 i_held_flit [`NOC_PORTS],
  output logic [`NOC_PORTS-1:0] o_grant,                   // Per input, frees its slot
  output flit_t                 o_out_flit [`NOC_PORTS],
  output logic [`NOC_PORTS-1:0] o_out_val                  // Per output strobe
);

  logic [`NOC_PORT_W-1:0] ptr [`NOC_PORTS];  // Priority pointer per output
  logic [`NOC_PORT_W-1:0] sel [`NOC_PORTS];  // Winning input per output
  logic [`NOC_PORTS-1:0]  hit;               // Output has at least one request

  // Round-robin arbitration
  // --------------------------------------------------
  always_comb begin
    int idx;
    o_grant = '0;
    for (int o = 0; o < `NOC_PORTS; o++) begin
      hit[o] = 1'b0;
      sel[o] = ptr[o];                               // Harmless default when idle
      // Walk the column starting at the pointer, first request wins
      for (int k = 0; k < `NOC_PORTS; k++) begin
        idx = (int'(ptr[o]) + k) % `NOC_PORTS;
        if (!hit[o] && i_req[idx][o]) begin
          hit[o] = 1'b1;
          sel[o] = idx[`NOC_PORT_W-1:0];
        end
      end
      // Each input asks for one output only, so OR-ing cannot double-grant
      if (hit[o]) begin
        o_grant[sel[o]] = 1'b1;
      end
    end
  end

  // Crossbar into output registers
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    for (int o = 0; o < `NOC_PORTS; o++) begin
      if (hit[o]) begin
        o_out_flit[o] <= i_held_flit[sel[o]];  // Payload only moves on a grant
      end
    end
  end

  // Output strobes and pointer update
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_out_val <= '0;
      for (int o = 0; o < `NOC_PORTS; o++) begin
        ptr[o] <= PORT_C;                     // Core has first priority after reset
      end
    end else begin
      o_out_val <= hit;                       // One cycle behind the grant
      for (int o = 0; o < `NOC_PORTS; o++) begin
        if (hit[o]) begin
          // Move past the winner so it goes last next time
          if (sel[o] == `NOC_PORT_W'(`NOC_PORTS - 1)) begin
            ptr[o] <= PORT_C;
          end else begin
            ptr[o] <= sel[o] + 1'b1;
          end
        end
      end
    end
  end

  // Worst wait is four other inputs, each served once

endmodule

//--- verification/noc_router_checker.sv
/*
  Router protocol checker
  Concurrent assertions on grants, output strobes and wait bound
*/

`timescale 1ns/1ps

`include "noc_cfg.svh"

module noc_router_checker
  import noc_pkg::*;
(
  input logic                  i_clk,
  input logic                  i_reset,
  input logic [`NOC_PORTS-1:0] i_held_val,
  input logic [`NOC_PORTS-1:0] i_grant,
  input port_req_t             i_req [`NOC_PORTS],
  input logic [`NOC_PORTS-1:0] i_out_val
);

  logic grant_fits;    // Grants agree with the request columns
  int   fail_cnt = 0;  // Assertion failures so far, watched by the testbench

  always_comb begin
    int cnt;
    grant_fits = 1'b1;
    for (int o = 0; o < `NOC_PORTS; o++) begin
      cnt = 0;
      for (int i = 0; i < `NOC_PORTS; i++) begin
        if (i_grant[i] && i_req[i][o]) cnt++;
      end
      if (cnt > 1) grant_fits = 1'b0;  // Two winners on one output
    end
    for (int i = 0; i < `NOC_PORTS; i++) begin
      if (i_grant[i] && i_req[i] == '0) grant_fits = 1'b0;
    end
  end

  a_quiet_after_reset : assert property (@(posedge i_clk)
    $fell(i_reset) |-> (i_out_val == '0) ##1 (i_out_val == '0))
    else begin
      $error("output strobe within two cycles of reset release");
      fail_cnt++;
    end

  a_grant_held : assert property (@(posedge i_clk) disable iff (i_reset)
    (i_grant & ~i_held_val) == '0)
    else begin
      $error("grant to an empty input slot");
      fail_cnt++;
    end

  a_grant_fits : assert property (@(posedge i_clk) disable iff (i_reset) grant_fits)
    else begin
      $error("grant vector does not match requests");
      fail_cnt++;
    end

  // Round-robin bounds the wait at four other winners
  for (genvar p = 0; p < `NOC_PORTS; p++) begin : g_wait
    a_wait_bound : assert property (@(posedge i_clk) disable iff (i_reset)
      $rose(i_held_val[p]) |-> ##[0:4] i_grant[p])
      else begin
        $error("held flit not granted within 5 cycles");
        fail_cnt++;
      end
  end

endmodule

bind noc_router noc_router_checker i_checker (
  .i_clk      (i_clk),
  .i_reset    (i_reset),
  .i_held_val (held_val),
  .i_grant    (grant),
  .i_req      (req),
  .i_out_val  (o_out_val)
);

//--- verification/noc_router_tb.sv
/*
  Mesh NoC router testbench
  Directed XY routing and contention tests, then a random soak
  checked against a per source and output FIFO model
*/

`timescale 1ns/1ps

`include "noc_cfg.svh"

module noc_router_tb
  import noc_pkg::*;
;

  localparam int X_NODE      = 1;     // Node column under test
  localparam int Y_NODE      = 2;     // Node row under test
  localparam int SOAK_FLITS  = 2000;
  localparam int TOTAL_FLITS = 1 + 12 + 3 + `NOC_PORTS + SOAK_FLITS;
  localparam int DEPTH       = 64;    // Model FIFO slots per pair
  localparam int PAIRS       = `NOC_PORTS * `NOC_PORTS;
  localparam int SEQ_W       = `NOC_DATA_W - 3;

  logic                  clk;
  logic                  reset;
  flit_t                 in_flit [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] in_val;
  logic [`NOC_PORTS-1:0] in_busy;
  flit_t                 out_flit [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] out_val;

  // Reference model state
  flit_t       exp_mem [PAIRS][DEPTH];  // Expected flits per source/output pair
  int          head [PAIRS];
  int          tail [PAIRS];
  int          pend_cnt [`NOC_PORTS];   // Undelivered flits per source
  int          seq [`NOC_PORTS];        // Next sequence number per source
  int          accepted;
  int          delivered;
  logic [31:0] rng_state;

  noc_router #(
    .X_LOC (X_NODE),
    .Y_LOC (Y_NODE)
  ) i_noc_router (
    .i_clk      (clk),
    .i_reset    (reset),
    .i_in_flit  (in_flit),
    .i_in_val   (in_val),
    .o_in_busy  (in_busy),
    .o_out_flit (out_flit),
    .o_out_val  (out_val)
  );

  // Clock and watchdog
  // --------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial begin
    repeat (8 + TOTAL_FLITS * 20) @(posedge clk);
    $display("Watchdog expired before all flits were delivered");
    $display("FAIL: see errors above");
    $fatal(1, "watchdog timeout");
  end

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "check failed");
  endtask

  // Random numbers
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // XY rule, x settled before y
  function automatic int expected_port(input int x, input int y);
    if (x > X_NODE) return int'(PORT_E);
    if (x < X_NODE) return int'(PORT_W);
    if (y > Y_NODE) return int'(PORT_N);
    if (y < Y_NODE) return int'(PORT_S);
    return int'(PORT_C);
  endfunction

  // Stimulus helpers
  // --------------------------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #1;
    in_val = '0;  // Strobes last one cycle
  endtask

  // Drive one flit on input p and queue it in the model
  task automatic strobe_port(input int p, input int x, input int y);
    flit_t f;
    int    idx;
    f.x_dest = x[`NOC_X_W-1:0];
    f.y_dest = y[`NOC_Y_W-1:0];
    f.data   = {p[2:0], seq[p][SEQ_W-1:0]};  // Source bits on top
    seq[p]++;
    in_flit[p] = f;
    in_val[p]  = 1'b1;
    idx = p * `NOC_PORTS + expected_port(x, y);
    assert (tail[idx] - head[idx] < DEPTH) else begin
      $display("Model FIFO overflow for source %0d", p);
      abort_run();
    end
    exp_mem[idx][tail[idx] % DEPTH] = f;
    tail[idx]++;
    pend_cnt[p]++;
    accepted++;
  endtask

  task automatic wait_idle();
    while (accepted != delivered || in_busy != '0) next_cycle();
  endtask

  // Scoreboard
  // --------------------------------------------------
  task automatic check_output(input int o);
    int    src;
    int    idx;
    flit_t exp;
    src = int'(out_flit[o].data[`NOC_DATA_W-1 -: 3]);
    assert (src < `NOC_PORTS) else begin
      $display("Output %0d carried a flit with unknown source %0d", o, src);
      abort_run();
    end
    idx = src * `NOC_PORTS + o;
    assert (tail[idx] != head[idx]) else begin
      $display("Flit from source %0d left on output %0d where none was due", src, o);
      abort_run();
    end
    exp = exp_mem[idx][head[idx] % DEPTH];
    assert (out_flit[o] == exp) else begin
      $display("ERR %0t o_out_flit[%0d] expected %h got %h", $time, o, exp, out_flit[o]);
      abort_run();
    end
    head[idx]++;
    pend_cnt[src]--;
    delivered++;
  endtask

  always @(negedge clk) begin  // Outputs are stable mid cycle
    if (!reset) begin
      for (int o = 0; o < `NOC_PORTS; o++) begin
        if (out_val[o]) check_output(o);
      end
    end
  end

  // Bound checker failures end the run too
  always @(negedge clk) begin
    assert (i_noc_router.i_checker.fail_cnt == 0) else begin
      $display("Protocol checker flagged an assertion failure");
      abort_run();
    end
  end

  // Tests
  // --------------------------------------------------
  task automatic run_local();
    wait_idle();
    next_cycle();
    strobe_port(int'(PORT_N), X_NODE, Y_NODE);
    next_cycle();
    assert (out_val == '0) else begin
      $display("ERR %0t o_out_val expected %b got %b", $time, 5'b0, out_val);
      abort_run();
    end
    next_cycle();
    assert (out_val == 5'b00001) else begin  // Bit 0 is the core output
      $display("ERR %0t o_out_val expected %b got %b", $time, 5'b00001, out_val);
      abort_run();
    end
  endtask

  task automatic run_contention();
    int remaining;
    int seen;
    int waited;
    wait_idle();
    next_cycle();
    for (int p = 0; p < `NOC_PORTS; p++) strobe_port(p, 3, p % 4);  // All head east
    seen   = 0;
    waited = 0;
    while (seen < `NOC_PORTS) begin
      next_cycle();
      // Busy follows what each source still has undelivered
      for (int s = 0; s < `NOC_PORTS; s++) begin
        remaining = pend_cnt[s];
        if (out_val[PORT_E] && out_flit[PORT_E].data[`NOC_DATA_W-1 -: 3] == s) remaining--;
        assert (in_busy[s] == (remaining > 0)) else begin
          $display("ERR %0t o_in_busy[%0d] expected %b got %b", $time, s, remaining > 0,
                   in_busy[s]);
          abort_run();
        end
      end
      if (out_val[PORT_E]) begin
        seen++;
      end else begin
        waited++;
        assert (seen == 0 && waited <= 1) else begin
          $display("East output idled while contending flits were still held");
          abort_run();
        end
      end
    end
  endtask

  initial begin
    int          sent;
    logic [31:0] r;
    reset     = 1'b1;
    in_val    = '0;
    accepted  = 0;
    delivered = 0;
    rng_state = 32'h707ef30e;
    for (int p = 0; p < `NOC_PORTS; p++) begin
      in_flit[p]  = '0;
      pend_cnt[p] = 0;
      seq[p]      = 0;
    end
    for (int i = 0; i < PAIRS; i++) begin
      head[i] = 0;
      tail[i] = 0;
    end
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
    run_local();
    for (int x = 0; x < `NOC_X_NODES; x++) begin  // X first, any y
      for (int y = 0; y < `NOC_Y_NODES; y++) begin
        if (x != X_NODE) begin
          wait_idle();
          next_cycle();
          strobe_port((x + y) % `NOC_PORTS, x, y);
        end
      end
    end
    for (int y = 0; y < `NOC_Y_NODES; y++) begin  // Then y
      if (y != Y_NODE) begin
        wait_idle();
        next_cycle();
        strobe_port(y, X_NODE, y);
      end
    end
    run_contention();
    // Random soak that obeys busy
    sent = 0;
    while (sent < SOAK_FLITS) begin
      next_cycle();
      for (int p = 0; p < `NOC_PORTS; p++) begin
        r = next_rand();
        if (r[0] && !in_busy[p] && sent < SOAK_FLITS) begin
          strobe_port(p, int'(r[9:8]), int'(r[11:10]));
          sent++;
        end
      end
    end
    next_cycle();
    while (in_busy != '0) next_cycle();  // Every slot granted
    next_cycle();                         // Last grants reach the outputs
    for (int i = 0; i < PAIRS; i++) begin
      assert (head[i] == tail[i]) else begin
        $display("Model FIFO %0d still holds undelivered flits", i);
        abort_run();
      end
    end
    assert (delivered == TOTAL_FLITS) else begin
      $display("ERR %0t delivered expected %0d got %0d", $time, TOTAL_FLITS, delivered);
      abort_run();
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule
